//--- zc_settings.svh
// Compressed stack sequencer settings
// Widths, register numbers and base opcodes shared by the design
`ifndef ZC_SETTINGS_SVH
`define ZC_SETTINGS_SVH

// Instruction and field widths
`define ZC_ILEN   32
`define ZC_CLEN   16
`define ZC_ADJ_W  12
`define ZC_CNT_W  4

// Fixed register numbers of the ABI
`define ZC_REG_RA 5'd1
`define ZC_REG_SP 5'd2
`define ZC_REG_A0 5'd10
`define ZC_REG_A1 5'd11

// Base ISA major opcodes
`define ZC_OP_LOAD  7'b0000011
`define ZC_OP_STORE 7'b0100011
`define ZC_OP_OPIMM 7'b0010011
`define ZC_OP_JALR  7'b1100111

`endif

//--- zc_seq_pkg.sv
// Compressed stack sequencer types
// Vector types, instruction kinds, sequence steps and s-register mapping
`include "zc_settings.svh"

package zc_seq_pkg;

  typedef logic [`ZC_ILEN-1:0]  instr_word_t;
  typedef logic [`ZC_CLEN-1:0]  cinstr_t;
  typedef logic [4:0]           regaddr_t;
  typedef logic [`ZC_ADJ_W-1:0] stack_adj_t;
  typedef logic [`ZC_CNT_W-1:0] seq_cnt_t;

  // Kind of sequenced instruction, SEQ_NONE for anything else
  typedef enum logic [2:0] {
    SEQ_NONE,
    SEQ_PUSH,
    SEQ_POP,
    SEQ_POPRET,
    SEQ_POPRETZ,
    SEQ_MVSA01,
    SEQ_MVA01S
  } seq_kind_e;

  // Step of a sequence
  // S_IDLE doubles as the first beat of a double move
  typedef enum logic [2:0] {
    S_IDLE,
    S_SREG,
    S_RA,
    S_SP,
    S_A0,
    S_RET,
    S_MOVE2
  } seq_state_e;

  // s0 and s1 sit at x8 and x9, s2 to s11 at x18 to x27
  function automatic regaddr_t sreg_to_regnum(input seq_cnt_t sreg);
    regaddr_t regnum;
    if (sreg < 4'd2) begin
      regnum = regaddr_t'(sreg) + 5'd8;
    end else begin
      regnum = regaddr_t'(sreg) + 5'd16;
    end
    return regnum;
  endfunction

endpackage

//--- seq_decode_if.sv
`timescale 1ns/1ps
// Decoded instruction bundle
// From the decoder to the sequence controller and the encoder
interface seq_decode_if;

  zc_seq_pkg::seq_kind_e  kind;
  // Number of s-registers in rlist, 0 to 12
  zc_seq_pkg::seq_cnt_t   sreg_count;
  // Aligned register area plus spimm blocks
  zc_seq_pkg::stack_adj_t total_adj;
  // s-register numbers of a double move
  zc_seq_pkg::seq_cnt_t   move_r1;
  zc_seq_pkg::seq_cnt_t   move_r2;

  modport dec (
    output kind, sreg_count, total_adj, move_r1, move_r2
  );

  modport user (
    input kind, sreg_count, total_adj, move_r1, move_r2
  );

endinterface

//--- seq_step_if.sv
`timescale 1ns/1ps
// Current sequence step
// From the sequence controller to the encoder
interface seq_step_if;

  zc_seq_pkg::seq_state_e state;
  // Beat index within the sequence
  zc_seq_pkg::seq_cnt_t   cnt;
  // s-register handled on this beat, counting down
  zc_seq_pkg::seq_cnt_t   sreg_idx;

  modport ctrl (
    output state, cnt, sreg_idx
  );

  modport enc (
    input state, cnt, sreg_idx
  );

endinterface

//--- zc_decoder.sv
`timescale 1ns/1ps
// Compressed stack and move decoder
// Picks the instruction kind, checks legality and sizes the stack frame
module zc_decoder (
  input  zc_seq_pkg::cinstr_t instr_i,
  seq_decode_if.dec           dec
);

  logic [3:0]             rlist;
  logic                   rlist_legal;
  logic                   move_legal;
  zc_seq_pkg::seq_cnt_t   sreg_count;
  zc_seq_pkg::stack_adj_t round_words;
  zc_seq_pkg::stack_adj_t base_adj;
  zc_seq_pkg::stack_adj_t spimm_adj;

  assign rlist = instr_i[7:4];

  // rlist 0 to 3 are reserved
  assign rlist_legal = (rlist >= 4'd4);
  // Both move registers must differ
  assign move_legal  = (instr_i[9:7] != instr_i[4:2]);

  ////////////////////
  // Kind select
  ////////////////////

  always_comb begin
    dec.kind = zc_seq_pkg::SEQ_NONE;
    // All sequenced instructions live in quadrant 2, funct3 101
    if ((instr_i[1:0] == 2'b10) && (instr_i[15:13] == 3'b101)) begin
      case (instr_i[12:8])
        // cm.push
        5'b11000: if (rlist_legal) dec.kind = zc_seq_pkg::SEQ_PUSH;
        // cm.pop
        5'b11010: if (rlist_legal) dec.kind = zc_seq_pkg::SEQ_POP;
        // cm.popretz
        5'b11100: if (rlist_legal) dec.kind = zc_seq_pkg::SEQ_POPRETZ;
        // cm.popret
        5'b11110: if (rlist_legal) dec.kind = zc_seq_pkg::SEQ_POPRET;
        default: begin
          // Double moves only use bits 12:10, bits 9:8 hold r1
          if ((instr_i[12:10] == 3'b011) && move_legal) begin
            if (instr_i[6:5] == 2'b01) begin
              dec.kind = zc_seq_pkg::SEQ_MVSA01;
            end else if (instr_i[6:5] == 2'b11) begin
              dec.kind = zc_seq_pkg::SEQ_MVA01S;
            end
          end
        end
      endcase
    end
  end

  ////////////////////
  // Frame size
  ////////////////////

  // rlist 15 jumps from s10 to s11, so it saves 12 registers
  always_comb begin
    if (rlist == 4'd15) begin
      sreg_count = 4'd12;
    end else if (rlist_legal) begin
      sreg_count = rlist - 4'd4;
    end else begin
      sreg_count = '0;
    end
  end

  // Words are s-regs plus ra, rounded up to whole 16-byte blocks
  assign round_words = zc_seq_pkg::stack_adj_t'(sreg_count) + 12'd4;
  assign base_adj    = (round_words >> 2) << 4;
  // spimm adds extra 16-byte blocks
  assign spimm_adj   = zc_seq_pkg::stack_adj_t'({instr_i[3:2], 4'b0000});

  assign dec.sreg_count = sreg_count;
  assign dec.total_adj  = base_adj + spimm_adj;

  // r1s' and r2s' are s0 to s7
  assign dec.move_r1 = {1'b0, instr_i[9:7]};
  assign dec.move_r2 = {1'b0, instr_i[4:2]};

endmodule

//--- seq_control.sv
`timescale 1ns/1ps
// Sequence controller
// Steps through each expansion one beat per accepted output transfer
module seq_control (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        valid_i,
  input  logic        ready_i,
  seq_decode_if.user  dec,
  seq_step_if.ctrl    step,
  output logic        valid_o,
  output logic        ready_o,
  output logic        seq_first_o,
  output logic        seq_last_o,
  output logic        seq_pushpop_o
);

  zc_seq_pkg::seq_state_e state_q;
  zc_seq_pkg::seq_state_e cur_state;
  zc_seq_pkg::seq_state_e state_n;
  zc_seq_pkg::seq_cnt_t   cnt_q;
  logic                   is_pushpop;
  logic                   last_step;

  assign is_pushpop = (dec.kind == zc_seq_pkg::SEQ_PUSH)   ||
                      (dec.kind == zc_seq_pkg::SEQ_POP)    ||
                      (dec.kind == zc_seq_pkg::SEQ_POPRET) ||
                      (dec.kind == zc_seq_pkg::SEQ_POPRETZ);

  // First beat of push/pop comes straight from the decoded kind
  always_comb begin
    cur_state = state_q;
    if ((state_q == zc_seq_pkg::S_IDLE) && is_pushpop) begin
      // Empty s-register list starts with ra
      cur_state = (dec.sreg_count == '0) ? zc_seq_pkg::S_RA : zc_seq_pkg::S_SREG;
    end
  end

  ////////////////////
  // Next step
  ////////////////////

  always_comb begin
    state_n   = zc_seq_pkg::S_IDLE;
    last_step = 1'b0;
    case (cur_state)
      // Only a double move is still in S_IDLE here
      zc_seq_pkg::S_IDLE:  state_n = zc_seq_pkg::S_MOVE2;
      zc_seq_pkg::S_SREG: begin
        if (cnt_q == dec.sreg_count - 4'd1) begin
          state_n = zc_seq_pkg::S_RA;
        end else begin
          state_n = zc_seq_pkg::S_SREG;
        end
      end
      zc_seq_pkg::S_RA:    state_n = zc_seq_pkg::S_SP;
      zc_seq_pkg::S_SP: begin
        // Plain push and pop end with the sp update
        if (dec.kind == zc_seq_pkg::SEQ_POPRETZ) begin
          state_n = zc_seq_pkg::S_A0;
        end else if (dec.kind == zc_seq_pkg::SEQ_POPRET) begin
          state_n = zc_seq_pkg::S_RET;
        end else begin
          last_step = 1'b1;
        end
      end
      zc_seq_pkg::S_A0:    state_n = zc_seq_pkg::S_RET;
      zc_seq_pkg::S_RET:   last_step = 1'b1;
      zc_seq_pkg::S_MOVE2: last_step = 1'b1;
      default:             last_step = 1'b1;
    endcase
  end

  ////////////////////
  // State and counter
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= zc_seq_pkg::S_IDLE;
      cnt_q   <= '0;
    end else if (!valid_o) begin
      // Nothing to sequence, start over
      state_q <= zc_seq_pkg::S_IDLE;
      cnt_q   <= '0;
    end else if (ready_i) begin
      if (last_step) begin
        state_q <= zc_seq_pkg::S_IDLE;
        cnt_q   <= '0;
      end else begin
        state_q <= state_n;
        cnt_q   <= cnt_q + 4'd1;
      end
    end
  end

  // Handshake and flags
  assign valid_o       = valid_i && (dec.kind != zc_seq_pkg::SEQ_NONE);
  // Input is consumed with the last transfer, or at once when not sequenced
  assign ready_o       = !valid_o || (ready_i && last_step);
  assign seq_first_o   = valid_o && (state_q == zc_seq_pkg::S_IDLE);
  assign seq_last_o    = valid_o && last_step;
  assign seq_pushpop_o = is_pushpop;

  assign step.state    = cur_state;
  assign step.cnt      = cnt_q;
  // s-registers go out highest first
  assign step.sreg_idx = dec.sreg_count - cnt_q - 4'd1;

endmodule

//--- instr_encoder.sv
`timescale 1ns/1ps
// Base instruction encoder
// Builds the 32-bit word and the stack offset of the current step
`include "zc_settings.svh"

module instr_encoder (
  seq_decode_if.user               dec,
  seq_step_if.enc                  step,
  output zc_seq_pkg::instr_word_t  instr_o
);

  logic                   is_push;
  zc_seq_pkg::stack_adj_t beat_bytes;
  zc_seq_pkg::stack_adj_t offset;
  zc_seq_pkg::stack_adj_t sp_adj;
  zc_seq_pkg::regaddr_t   sreg_num;
  zc_seq_pkg::regaddr_t   move_s1;
  zc_seq_pkg::regaddr_t   move_s2;

  // addi rd, rs1, imm
  function automatic zc_seq_pkg::instr_word_t addi_word(
    input zc_seq_pkg::regaddr_t   rd,
    input zc_seq_pkg::regaddr_t   rs1,
    input zc_seq_pkg::stack_adj_t imm
  );
    return {imm, rs1, 3'b000, rd, `ZC_OP_OPIMM};
  endfunction

  // sw or lw of one register relative to sp
  function automatic zc_seq_pkg::instr_word_t mem_word(
    input logic                   store,
    input zc_seq_pkg::regaddr_t   data_reg,
    input zc_seq_pkg::stack_adj_t off
  );
    zc_seq_pkg::instr_word_t word;
    if (store) begin
      word = {off[`ZC_ADJ_W-1:5], data_reg, `ZC_REG_SP, 3'b010, off[4:0], `ZC_OP_STORE};
    end else begin
      word = {off, `ZC_REG_SP, 3'b010, data_reg, `ZC_OP_LOAD};
    end
    return word;
  endfunction

  assign is_push = (dec.kind == zc_seq_pkg::SEQ_PUSH);

  ////////////////////
  // Stack offset
  ////////////////////

  // Beat k sits 4(k+1) bytes below the frame top
  assign beat_bytes = (zc_seq_pkg::stack_adj_t'(step.cnt) + 12'd1) << 2;
  // Pops first step back up by the whole frame
  assign offset     = is_push ? (12'd0 - beat_bytes) : (dec.total_adj - beat_bytes);
  assign sp_adj     = is_push ? (12'd0 - dec.total_adj) : dec.total_adj;

  assign sreg_num = zc_seq_pkg::sreg_to_regnum(step.sreg_idx);
  assign move_s1  = zc_seq_pkg::sreg_to_regnum(dec.move_r1);
  assign move_s2  = zc_seq_pkg::sreg_to_regnum(dec.move_r2);

  ////////////////////
  // Word assembly
  ////////////////////

  always_comb begin
    instr_o = '0;
    case (step.state)
      zc_seq_pkg::S_IDLE: begin
        // First half of a double move
        if (dec.kind == zc_seq_pkg::SEQ_MVSA01) begin
          instr_o = addi_word(move_s1, `ZC_REG_A0, '0);
        end else if (dec.kind == zc_seq_pkg::SEQ_MVA01S) begin
          instr_o = addi_word(`ZC_REG_A0, move_s1, '0);
        end
      end
      zc_seq_pkg::S_SREG:  instr_o = mem_word(is_push, sreg_num, offset);
      zc_seq_pkg::S_RA:    instr_o = mem_word(is_push, `ZC_REG_RA, offset);
      // sp moves down on push and back up on pop
      zc_seq_pkg::S_SP:    instr_o = addi_word(`ZC_REG_SP, `ZC_REG_SP, sp_adj);
      // popretz clears a0 with addi a0, x0, 0
      zc_seq_pkg::S_A0:    instr_o = addi_word(`ZC_REG_A0, 5'd0, '0);
      // jalr x0, 0(ra)
      zc_seq_pkg::S_RET:   instr_o = {12'd0, `ZC_REG_RA, 3'b000, 5'd0, `ZC_OP_JALR};
      zc_seq_pkg::S_MOVE2: begin
        if (dec.kind == zc_seq_pkg::SEQ_MVSA01) begin
          instr_o = addi_word(move_s2, `ZC_REG_A1, '0);
        end else begin
          instr_o = addi_word(`ZC_REG_A1, move_s2, '0);
        end
      end
      default:             instr_o = '0;
    endcase
  end

endmodule

//--- zc_sequencer.sv
`timescale 1ns/1ps
// Compressed stack and move sequencer
// Expands one 16-bit instruction into a run of 32-bit base instructions
module zc_sequencer (
  input  logic                    clk,
  input  logic                    rst_n,
  // Upstream side
  input  zc_seq_pkg::cinstr_t     instr_i,
  input  logic                    valid_i,
  output logic                    ready_o,
  // Downstream side
  output zc_seq_pkg::instr_word_t instr_o,
  output logic                    valid_o,
  input  logic                    ready_i,
  // Sequence flags
  output logic                    seq_first_o,
  output logic                    seq_last_o,
  output logic                    seq_pushpop_o
);

  seq_decode_if dec_if ();
  seq_step_if   step_if ();

  // Input side
  zc_decoder zc_decoder_i (
    .instr_i (instr_i),
    .dec     (dec_if)
  );

  // Step tracking and handshake
  seq_control seq_control_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .valid_i       (valid_i),
    .ready_i       (ready_i),
    .dec           (dec_if),
    .step          (step_if),
    .valid_o       (valid_o),
    .ready_o       (ready_o),
    .seq_first_o   (seq_first_o),
    .seq_last_o    (seq_last_o),
    .seq_pushpop_o (seq_pushpop_o)
  );

  // Output side
  instr_encoder instr_encoder_i (
    .dec     (dec_if),
    .step    (step_if),
    .instr_o (instr_o)
  );

endmodule

//--- tb_seq_checker.sv
`timescale 1ns/1ps
// Sequencer checker for the testbench
// Rebuilds each expected expansion from the input word and compares every beat
module tb_seq_checker (
  input  logic                    clk,
  input  logic                    rst_n,
  input  zc_seq_pkg::cinstr_t     cinstr_i,
  input  logic                    in_valid_i,
  input  logic                    in_ready_i,
  input  zc_seq_pkg::instr_word_t word_i,
  input  logic                    out_valid_i,
  input  logic                    out_ready_i,
  input  logic                    first_i,
  input  logic                    last_i,
  input  logic                    pushpop_i,
  output int                      entry_cnt_o,
  output int                      fail_cnt_o,
  output int                      error_cnt_o
);

  zc_seq_pkg::instr_word_t exp_words [16];
  int                      exp_n;
  logic                    exp_pp;
  int                      beat;
  logic                    entry_bad;

  // s0, s1 at x8, x9 and s2 to s11 at x18 to x27
  function automatic logic [4:0] sreg_addr(input int idx);
    if (idx < 2) begin
      return 5'(idx + 8);
    end
    return 5'(idx + 16);
  endfunction

  // I-type layout, used for lw, addi and jalr
  function automatic zc_seq_pkg::instr_word_t itype_word(input logic [11:0] imm,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  // sw rs2, imm(sp)
  function automatic zc_seq_pkg::instr_word_t store_word(input logic [4:0] rs2,
      input logic [11:0] imm);
    return {imm[11:5], rs2, 5'd2, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  ////////////////////
  // Expected sequence
  ////////////////////

  task automatic expand_instr(input zc_seq_pkg::cinstr_t c);
    logic [3:0]  rlist;
    logic [11:0] off;
    logic [4:0]  data_reg;
    int          kind;
    int          cnt;
    int          total;
    rlist  = c[7:4];
    kind   = 0;
    exp_n  = 0;
    exp_pp = 1'b0;
    // 1 push, 2 pop, 3 popret, 4 popretz, 5 mvsa01, 6 mva01s
    if ((c[1:0] == 2'b10) && (c[15:13] == 3'b101)) begin
      if (rlist >= 4'd4) begin
        case (c[12:8])
          5'b11000: kind = 1;
          5'b11010: kind = 2;
          5'b11110: kind = 3;
          5'b11100: kind = 4;
          default:  kind = 0;
        endcase
      end
      if ((c[12:10] == 3'b011) && (c[9:7] != c[4:2])) begin
        if (c[6:5] == 2'b01) begin
          kind = 5;
        end else if (c[6:5] == 2'b11) begin
          kind = 6;
        end
      end
    end
    if ((kind >= 1) && (kind <= 4)) begin
      exp_pp = 1'b1;
      cnt    = (rlist == 4'd15) ? 12 : int'(rlist) - 4;
      // ra plus s-regs rounded up to 16 bytes, then spimm blocks
      total  = ((cnt + 1) * 4 + 15) / 16 * 16 + int'(c[3:2]) * 16;
      for (int k = 0; k <= cnt; k++) begin
        off      = (kind == 1) ? 12'(-4 * (k + 1)) : 12'(total - 4 * (k + 1));
        data_reg = (k == cnt) ? 5'd1 : sreg_addr(cnt - 1 - k);
        if (kind == 1) begin
          exp_words[k] = store_word(data_reg, off);
        end else begin
          exp_words[k] = itype_word(off, 5'd2, 3'b010, data_reg, 7'b0000011);
        end
      end
      off = (kind == 1) ? 12'(-total) : 12'(total);
      exp_words[cnt + 1] = itype_word(off, 5'd2, 3'b000, 5'd2, 7'b0010011);
      exp_n = cnt + 2;
      if (kind == 4) begin
        exp_words[exp_n] = itype_word(12'd0, 5'd0, 3'b000, 5'd10, 7'b0010011);
        exp_n = exp_n + 1;
      end
      if (kind >= 3) begin
        exp_words[exp_n] = itype_word(12'd0, 5'd1, 3'b000, 5'd0, 7'b1100111);
        exp_n = exp_n + 1;
      end
    end else if (kind == 5) begin
      exp_words[0] = itype_word(12'd0, 5'd10, 3'b000, sreg_addr(c[9:7]), 7'b0010011);
      exp_words[1] = itype_word(12'd0, 5'd11, 3'b000, sreg_addr(c[4:2]), 7'b0010011);
      exp_n = 2;
    end else if (kind == 6) begin
      exp_words[0] = itype_word(12'd0, sreg_addr(c[9:7]), 3'b000, 5'd10, 7'b0010011);
      exp_words[1] = itype_word(12'd0, sreg_addr(c[4:2]), 3'b000, 5'd11, 7'b0010011);
      exp_n = 2;
    end
  endtask

  task automatic report_mismatch(input string msg);
    $display("mismatch at %0t: entry %0d %s", $time, entry_cnt_o, msg);
    error_cnt_o = error_cnt_o + 1;
    entry_bad   = 1'b1;
  endtask

  // One line per consumed input word
  task automatic close_entry();
    $display("entry %0d instr %h beats %0d: %s", entry_cnt_o, cinstr_i, beat,
             entry_bad ? "bad" : "ok");
    if (entry_bad) begin
      fail_cnt_o = fail_cnt_o + 1;
    end
    entry_cnt_o = entry_cnt_o + 1;
    beat        = 0;
    entry_bad   = 1'b0;
  endtask

  initial begin
    entry_cnt_o = 0;
    fail_cnt_o  = 0;
    error_cnt_o = 0;
    beat        = 0;
    entry_bad   = 1'b0;
  end

  ////////////////////
  // Beat compare
  ////////////////////

  always @(posedge clk) begin
    if (!rst_n) begin
      beat      = 0;
      entry_bad = 1'b0;
    end else if (!in_valid_i) begin
      // Idle outputs stay quiet
      if (out_valid_i || first_i || last_i) begin
        report_mismatch("valid_o or a flag high while valid_i is low");
      end
    end else begin
      expand_instr(cinstr_i);
      if (out_valid_i !== (exp_n != 0)) begin
        report_mismatch($sformatf("valid_o %b with %0d expected beats", out_valid_i, exp_n));
      end
      if (out_valid_i && out_ready_i) begin
        if (beat >= exp_n) begin
          report_mismatch($sformatf("extra beat %0d instr_o %h", beat, word_i));
        end else begin
          if (word_i !== exp_words[beat]) begin
            report_mismatch($sformatf("beat %0d instr_o %h expected %h",
                                      beat, word_i, exp_words[beat]));
          end
          if (first_i !== (beat == 0)) begin
            report_mismatch($sformatf("beat %0d seq_first_o %b", beat, first_i));
          end
          if (last_i !== (beat == exp_n - 1)) begin
            report_mismatch($sformatf("beat %0d seq_last_o %b", beat, last_i));
          end
          if (pushpop_i !== exp_pp) begin
            report_mismatch($sformatf("beat %0d seq_pushpop_o %b", beat, pushpop_i));
          end
        end
        beat = beat + 1;
      end
      // ready_o may only rise together with the final transfer
      if (in_ready_i) begin
        if (beat != exp_n) begin
          report_mismatch($sformatf("ready_o high after %0d of %0d beats", beat, exp_n));
        end
        close_entry();
      end
    end
  end

endmodule

//--- tb_zc_sequencer.sv
`timescale 1ns/1ps
// Testbench for the compressed stack sequencer
// Applies a table of compressed words with optional random back-pressure
module tb_zc_sequencer;

  localparam int wait_limit = 100;

  logic                    clk;
  logic                    rst_n;
  zc_seq_pkg::cinstr_t     instr_i;
  logic                    valid_i;
  logic                    ready_i;
  zc_seq_pkg::instr_word_t instr_o;
  logic                    valid_o;
  logic                    ready_o;
  logic                    seq_first_o;
  logic                    seq_last_o;
  logic                    seq_pushpop_o;

  // Stimulus table, one compressed word and a stall flag per entry
  zc_seq_pkg::cinstr_t tbl_instr [$];
  logic                tbl_stall [$];
  logic [31:0]         rnd_state;
  logic                timed_out;
  int                  entry_cnt;
  int                  fail_cnt;
  int                  error_cnt;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // push, pop, popret and popretz share one layout
  function automatic zc_seq_pkg::cinstr_t stack_op(input logic [4:0] f5,
      input logic [3:0] rlist, input logic [1:0] spimm);
    return {3'b101, f5, rlist, spimm, 2'b10};
  endfunction

  // Double move with r1s' in 9:7 and r2s' in 4:2
  function automatic zc_seq_pkg::cinstr_t move_op(input logic [1:0] f2,
      input logic [2:0] r1, input logic [2:0] r2);
    return {3'b101, 3'b011, r1, f2, r2, 2'b10};
  endfunction

  function automatic logic [3:0] rlist_pick(input int i);
    case (i)
      0:       return 4'd4;
      1:       return 4'd5;
      2:       return 4'd10;
      default: return 4'd15;
    endcase
  endfunction

  function automatic logic [4:0] stack_funct(input int i);
    case (i)
      0:       return 5'b11000;
      1:       return 5'b11010;
      2:       return 5'b11110;
      default: return 5'b11100;
    endcase
  endfunction

  task automatic add_entry(input zc_seq_pkg::cinstr_t c, input logic stall);
    tbl_instr.push_back(c);
    tbl_stall.push_back(stall);
  endtask

  // Stalled entries see ready_i low about half the time
  task automatic drive_ready(input logic stall);
    rnd_state = xorshift32(rnd_state);
    ready_i <= stall ? rnd_state[0] : 1'b1;
  endtask

  zc_sequencer zc_sequencer_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .instr_i       (instr_i),
    .valid_i       (valid_i),
    .ready_o       (ready_o),
    .instr_o       (instr_o),
    .valid_o       (valid_o),
    .ready_i       (ready_i),
    .seq_first_o   (seq_first_o),
    .seq_last_o    (seq_last_o),
    .seq_pushpop_o (seq_pushpop_o)
  );

  tb_seq_checker tb_seq_checker_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .cinstr_i    (instr_i),
    .in_valid_i  (valid_i),
    .in_ready_i  (ready_o),
    .word_i      (instr_o),
    .out_valid_i (valid_o),
    .out_ready_i (ready_i),
    .first_i     (seq_first_o),
    .last_i      (seq_last_o),
    .pushpop_i   (seq_pushpop_o),
    .entry_cnt_o (entry_cnt),
    .fail_cnt_o  (fail_cnt),
    .error_cnt_o (error_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin
    logic done;
    int   cycles;
    rst_n     = 1'b0;
    instr_i   = '0;
    valid_i   = 1'b0;
    ready_i   = 1'b1;
    rnd_state = 32'h40ee;
    timed_out = 1'b0;

    // Every stack kind with each rlist, spimm follows the rlist slot
    for (int op = 0; op < 4; op++) begin
      for (int i = 0; i < 4; i++) begin
        add_entry(stack_op(stack_funct(op), rlist_pick(i), 2'(i)), i[0]);
      end
    end
    add_entry(move_op(2'b01, 3'd1, 3'd2), 1'b0);
    add_entry(move_op(2'b11, 3'd7, 3'd0), 1'b1);
    add_entry(move_op(2'b01, 3'd3, 3'd3), 1'b0);
    add_entry(move_op(2'b11, 3'd5, 3'd5), 1'b1);
    // Not sequenced, or reserved rlist
    add_entry(16'h4501, 1'b0);
    add_entry(stack_op(5'b11000, 4'd3, 2'd0), 1'b1);
    add_entry(stack_op(5'b11110, 4'd0, 2'd2), 1'b0);
    add_entry(16'h0000, 1'b1);

    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    for (int e = 0; (e < tbl_instr.size()) && !timed_out; e++) begin
      instr_i <= tbl_instr[e];
      valid_i <= 1'b1;
      drive_ready(tbl_stall[e]);
      done   = 1'b0;
      cycles = 0;
      // Hold the word until the sequencer consumes it
      while (!done && (cycles < wait_limit)) begin
        @(posedge clk);
        cycles = cycles + 1;
        if (ready_o) begin
          done = 1'b1;
        end else begin
          drive_ready(tbl_stall[e]);
        end
      end
      if (!done) begin
        $display("timeout: ready_o never rose for entry %0d", e);
        timed_out = 1'b1;
      end
    end

    valid_i <= 1'b0;
    ready_i <= 1'b1;
    repeat (2) @(posedge clk);

    $display("entries %0d, bad entries %0d, errors %0d", entry_cnt, fail_cnt, error_cnt);
    if (entry_cnt != tbl_instr.size()) begin
      $display("checker saw %0d of %0d entries", entry_cnt, tbl_instr.size());
    end
    if (timed_out || (error_cnt != 0) || (fail_cnt != 0) ||
        (entry_cnt != tbl_instr.size())) begin
      $display("Result: FAILED");
    end else begin
      $display("Result: PASSED");
    end
    $finish;
  end

endmodule

//--- files.f
+incdir+.
zc_seq_pkg.sv
seq_decode_if.sv
seq_step_if.sv
zc_decoder.sv
seq_control.sv
instr_encoder.sv
zc_sequencer.sv
tb_seq_checker.sv
tb_zc_sequencer.sv

//--- Bender.yml
package:
  name: zc_sequencer

sources:
  - include_dirs:
      - .
    files:
      - zc_seq_pkg.sv
      - seq_decode_if.sv
      - seq_step_if.sv
      - zc_decoder.sv
      - seq_control.sv
      - instr_encoder.sv
      - zc_sequencer.sv
  - target: test
    files:
      - tb_seq_checker.sv
      - tb_zc_sequencer.sv
